/* rv_core_config.svh */
// RV32I subset core configuration
// Widths, reset and interrupt addresses, micro-ROM size
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

`define RV_XLEN          32
`define RV_NREGS         16
`define RV_RESET_PC      32'h0000_0000
`define RV_IRQ_VECTOR    32'h0000_0100
// Must fit a 12-bit signed store offset from x0
`define RV_MAILBOX_ADDR  32'h0000_0400
`define RV_UROM_DEPTH    4

`endif

/* rv_isa_pkg.sv */
// Instruction-set types for the RV32I subset core
// Opcode and funct encodings, ALU operations, word and register index
`include "rv_core_config.svh"

package rv_isa_pkg;

   typedef logic [`RV_XLEN-1:0]          word_t;
   typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;
   typedef logic [6:0]                   opcode_t;
   typedef logic [2:0]                   funct3_t;
   typedef logic [6:0]                   funct7_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_PASS_B
   } alu_op_t;

   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_LOAD   = 7'b0000011;
   localparam opcode_t OPC_STORE  = 7'b0100011;
   localparam opcode_t OPC_BRANCH = 7'b1100011;
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_SYSTEM = 7'b1110011;

   localparam funct3_t F3_ADD_SUB = 3'b000;
   localparam funct3_t F3_OR      = 3'b110;
   localparam funct3_t F3_AND     = 3'b111;
   localparam funct3_t F3_WORD    = 3'b010;
   localparam funct3_t F3_BEQ     = 3'b000;
   localparam funct3_t F3_BNE     = 3'b001;

   localparam funct7_t F7_BASE = 7'b0000000;
   localparam funct7_t F7_ALT  = 7'b0100000;

   localparam word_t MRET_WORD = 32'h3020_0073;
   // addi x0, x0, 0
   localparam word_t NOP_WORD  = 32'h0000_0013;

endpackage

/* rv_ctrl_pkg.sv */
// Flow-control types for the RV32I subset core
// Pipeline state and micro-ROM address
`include "rv_core_config.svh"

package rv_ctrl_pkg;

   // RESET holds one cycle, BRANCH is the bubble after a redirect,
   // WAITLD holds the data strobes until data_ready
   typedef enum logic [1:0] {
      PSTATE_RESET,
      PSTATE_CONT,
      PSTATE_BRANCH,
      PSTATE_WAITLD
   } pstate_t;

   typedef logic [$clog2(`RV_UROM_DEPTH)-1:0] urom_addr_t;

endpackage

/* rv_decode.sv */
// Instruction decoder
// Register indices, immediate, ALU operation and class strobes.
// Formats without rs2 decode it as x0, which selects the immediate
`timescale 1ns/1ps

module rv_decode (
   input  rv_isa_pkg::word_t    inst_word,
   output rv_isa_pkg::reg_idx_t rs1,
   output rv_isa_pkg::reg_idx_t rs2,
   output rv_isa_pkg::reg_idx_t rd,
   output rv_isa_pkg::word_t    imm,
   output rv_isa_pkg::alu_op_t  alu_op,
   output logic                 is_load,
   output logic                 is_store,
   output logic                 is_branch,
   output logic                 is_branch_ne,
   output logic                 is_jal,
   output logic                 is_mret,
   output logic                 reg_write
);
   import rv_isa_pkg::*;

   opcode_t opcode;
   funct3_t funct3;
   funct7_t funct7;
   word_t   imm_i;
   word_t   imm_s;
   word_t   imm_b;
   word_t   imm_j;

   assign opcode = inst_word[6:0];
   assign funct3 = inst_word[14:12];
   assign funct7 = inst_word[31:25];

   assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
   assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
   assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7], inst_word[30:25],
                   inst_word[11:8], 1'b0};
   assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12], inst_word[20],
                   inst_word[30:21], 1'b0};

   always_comb begin
      rs1          = '0;
      rs2          = '0;
      rd           = '0;
      imm          = '0;
      alu_op       = ALU_PASS_B;
      is_load      = 1'b0;
      is_store     = 1'b0;
      is_branch    = 1'b0;
      is_branch_ne = 1'b0;
      is_jal       = 1'b0;
      is_mret      = 1'b0;
      reg_write    = 1'b0;
      case (opcode)
         OPC_OP: begin
            case ({funct7, funct3})
               {F7_BASE, F3_ADD_SUB}: alu_op = ALU_ADD;
               {F7_ALT, F3_ADD_SUB}:  alu_op = ALU_SUB;
               {F7_BASE, F3_AND}:     alu_op = ALU_AND;
               {F7_BASE, F3_OR}:      alu_op = ALU_OR;
               default:               alu_op = ALU_PASS_B;
            endcase
            if (alu_op != ALU_PASS_B) begin
               rs1       = inst_word[15 +: $bits(reg_idx_t)];
               rs2       = inst_word[20 +: $bits(reg_idx_t)];
               rd        = inst_word[7 +: $bits(reg_idx_t)];
               reg_write = 1'b1;
            end
         end
         OPC_OP_IMM, OPC_LOAD: begin
            // Only ADDI and LW exist in this subset
            if (funct3 == (opcode == OPC_LOAD ? F3_WORD : F3_ADD_SUB)) begin
               rs1       = inst_word[15 +: $bits(reg_idx_t)];
               rd        = inst_word[7 +: $bits(reg_idx_t)];
               imm       = imm_i;
               alu_op    = ALU_ADD;
               is_load   = (opcode == OPC_LOAD);
               reg_write = 1'b1;
            end
         end
         OPC_STORE: begin
            if (funct3 == F3_WORD) begin
               rs1      = inst_word[15 +: $bits(reg_idx_t)];
               rs2      = inst_word[20 +: $bits(reg_idx_t)];
               imm      = imm_s;
               alu_op   = ALU_ADD;
               is_store = 1'b1;
            end
         end
         OPC_BRANCH: begin
            if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
               rs1          = inst_word[15 +: $bits(reg_idx_t)];
               rs2          = inst_word[20 +: $bits(reg_idx_t)];
               imm          = imm_b;
               is_branch    = 1'b1;
               is_branch_ne = (funct3 == F3_BNE);
            end
         end
         OPC_JAL: begin
            rd        = inst_word[7 +: $bits(reg_idx_t)];
            imm       = imm_j;
            is_jal    = 1'b1;
            reg_write = 1'b1;
         end
         OPC_SYSTEM: is_mret = (inst_word == MRET_WORD);
         default: ;
      endcase
   end

endmodule

/* rv_execute.sv */
// Execute stage
// Register file, ALU and branch compare, giving result, store data and target.
// During micro-ROM code, x0 on the rs2 side reads the mailbox marker and
// branch targets are taken from address zero
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_execute (
   input  logic                 clk,
   input  logic                 rst_n,
   input  rv_isa_pkg::reg_idx_t rs1,
   input  rv_isa_pkg::reg_idx_t rs2,
   input  rv_isa_pkg::reg_idx_t rd,
   input  rv_isa_pkg::word_t    imm,
   input  rv_isa_pkg::alu_op_t  alu_op,
   input  logic                 is_branch,
   input  logic                 is_branch_ne,
   input  logic                 is_jal,
   input  logic                 is_store,
   input  logic                 allow_hidden_use_of_x0,
   input  logic                 wb_en,
   input  rv_isa_pkg::word_t    wb_data,
   input  rv_isa_pkg::word_t    pc,
   output rv_isa_pkg::word_t    alu_result,
   output rv_isa_pkg::word_t    store_data,
   output rv_isa_pkg::word_t    branch_target,
   output logic                 branch_taken
);
   import rv_isa_pkg::*;

   localparam word_t IRQ_MARKER = word_t'(1);

   word_t rf [`RV_NREGS];
   word_t rs1_val;
   word_t rs2_val;
   word_t op_b;
   logic  operands_eq;

   // x0 is never written, so it reads zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            rf[i] <= '0;
         end
      end else if (wb_en && rd != '0) begin
         rf[rd] <= wb_data;
      end
   end

   assign rs1_val = rf[rs1];
   assign rs2_val = (allow_hidden_use_of_x0 && rs2 == '0) ? IRQ_MARKER : rf[rs2];

   // Stores use rs2 as data only
   assign op_b = (is_store || rs2 == '0) ? imm : rs2_val;

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_result = rs1_val + op_b;
         ALU_SUB: alu_result = rs1_val - op_b;
         ALU_AND: alu_result = rs1_val & op_b;
         ALU_OR:  alu_result = rs1_val | op_b;
         default: alu_result = op_b;
      endcase
   end

   assign store_data    = rs2_val;
   assign operands_eq   = (rs1_val == rs2_val);
   assign branch_taken  = is_jal || (is_branch && (operands_eq != is_branch_ne));
   assign branch_target = (allow_hidden_use_of_x0 ? '0 : pc) + imm;

endmodule

/* rv_result.sv */
// Result stage
// PC register, next-PC select, data port and write-back select.
// code_addr is the address fetched for the next cycle; its word comes
// back on code_rdata one cycle later
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_result (
   input  logic              clk,
   input  logic              rst_n,
   input  rv_isa_pkg::word_t alu_result,
   input  rv_isa_pkg::word_t store_data,
   input  rv_isa_pkg::word_t data_rdata,
   input  rv_isa_pkg::word_t branch_target,
   input  rv_isa_pkg::word_t epc,
   input  logic              is_load,
   input  logic              is_store,
   input  logic              is_jal,
   input  logic              reg_write,
   input  logic              stall,
   input  logic              data_access_cycle,
   input  logic              data_ready,
   input  logic              output_new_pc,
   input  logic              irq_return,
   output rv_isa_pkg::word_t pc,
   output rv_isa_pkg::word_t code_addr,
   output rv_isa_pkg::word_t data_addr,
   output rv_isa_pkg::word_t data_wdata,
   output rv_isa_pkg::word_t wb_data,
   output logic              data_read,
   output logic              data_write,
   output logic              wb_en
);
   import rv_isa_pkg::*;

   word_t seq_pc;
   word_t next_pc;

   assign seq_pc = pc + word_t'(4);

   always_comb begin
      if (irq_return) begin
         next_pc = epc;
      end else if (output_new_pc) begin
         next_pc = branch_target;
      end else begin
         next_pc = seq_pc;
      end
   end

   // Held PC is refetched while stalled
   assign code_addr = stall ? pc : next_pc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= `RV_RESET_PC;
      end else begin
         pc <= code_addr;
      end
   end

   assign data_addr  = alu_result;
   assign data_wdata = store_data;
   assign data_read  = data_access_cycle && is_load;
   assign data_write = data_access_cycle && is_store;

   assign wb_data = is_load ? data_rdata : (is_jal ? seq_pc : alu_result);
   assign wb_en   = reg_write && !stall && (!is_load || data_ready);

endmodule

/* rv_flow_ctrl.sv */
// Pipeline flow controller
// State machine for data waits and branch bubbles, interrupt entry through
// a small micro-ROM, and return from interrupt on MRET
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_flow_ctrl (
   input  logic              clk,
   input  logic              rst_n,
   input  rv_isa_pkg::word_t code_rdata,
   input  logic              code_ready,
   input  logic              branch_taken,
   input  logic              is_load,
   input  logic              is_store,
   input  logic              is_mret,
   input  logic              data_ready,
   input  logic              irq,
   input  rv_isa_pkg::word_t pc,
   output rv_isa_pkg::word_t inst_word,
   output rv_isa_pkg::word_t epc,
   output logic              stall,
   output logic              output_new_pc,
   output logic              data_access_cycle,
   output logic              irq_ack,
   output logic              irq_return,
   output logic              allow_hidden_use_of_x0
);
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;

   localparam word_t MAILBOX = `RV_MAILBOX_ADDR;
   localparam word_t VECTOR  = `RV_IRQ_VECTOR;

   // Entry sequence: sw x0, MAILBOX(x0) then jal x0, VECTOR
   localparam word_t UROM [`RV_UROM_DEPTH] = '{
      {MAILBOX[11:5], 5'd0, 5'd0, F3_WORD, MAILBOX[4:0], OPC_STORE},
      {VECTOR[20], VECTOR[10:1], VECTOR[11], VECTOR[19:12], 5'd0, OPC_JAL},
      NOP_WORD,
      NOP_WORD
   };

   pstate_t    pstate_r;
   pstate_t    pstate_next;
   logic       int_state_r;
   logic       use_urom;
   urom_addr_t urom_addr_r;
   word_t      inst_hold_r;
   word_t      epc_r;
   word_t      fetch_word;
   logic       inst_valid;
   logic       irq_window;
   logic       take_irq;
   logic       clr_urom;

   assign fetch_word = use_urom ? UROM[urom_addr_r] : code_rdata;
   assign inst_valid = use_urom || code_ready;
   // The code port may drop ready while a data access waits
   assign inst_word  = (pstate_r == PSTATE_WAITLD) ? inst_hold_r : fetch_word;

   always_comb begin
      pstate_next       = pstate_r;
      stall             = 1'b1;
      output_new_pc     = 1'b0;
      data_access_cycle = 1'b0;
      irq_return        = 1'b0;
      irq_window        = 1'b0;
      clr_urom          = 1'b0;
      case (pstate_r)
         PSTATE_RESET: pstate_next = PSTATE_CONT;
         PSTATE_CONT: begin
            if (inst_valid) begin
               if (branch_taken) begin
                  stall         = 1'b0;
                  output_new_pc = 1'b1;
                  pstate_next   = PSTATE_BRANCH;
               end else if (is_mret && int_state_r) begin
                  stall         = 1'b0;
                  output_new_pc = 1'b1;
                  irq_return    = 1'b1;
                  pstate_next   = PSTATE_BRANCH;
               end else if (is_load || is_store) begin
                  pstate_next = PSTATE_WAITLD;
               end else begin
                  stall      = 1'b0;
                  irq_window = 1'b1;
               end
            end
         end
         PSTATE_BRANCH: begin
            // Bubble until the redirected fetch is ready
            if (code_ready) begin
               pstate_next = PSTATE_CONT;
               clr_urom    = 1'b1;
            end
         end
         PSTATE_WAITLD: begin
            data_access_cycle = 1'b1;
            if (data_ready) begin
               stall       = 1'b0;
               irq_window  = 1'b1;
               pstate_next = PSTATE_CONT;
            end
         end
         default: pstate_next = PSTATE_CONT;
      endcase
   end

   assign take_irq = irq_window && irq && !int_state_r && !use_urom;
   assign irq_ack  = take_irq;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pstate_r    <= PSTATE_RESET;
         int_state_r <= 1'b0;
         use_urom    <= 1'b0;
         urom_addr_r <= '0;
      end else begin
         pstate_r <= pstate_next;
         if (take_irq) begin
            int_state_r <= 1'b1;
         end else if (irq_return) begin
            int_state_r <= 1'b0;
         end
         if (take_irq) begin
            use_urom <= 1'b1;
         end else if (clr_urom) begin
            use_urom <= 1'b0;
         end
         // Step as entry words retire
         if (take_irq) begin
            urom_addr_r <= '0;
         end else if (use_urom && !stall) begin
            urom_addr_r <= urom_addr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_irq) begin
         epc_r <= pc + word_t'(4);
      end
      if (pstate_r == PSTATE_CONT) begin
         inst_hold_r <= fetch_word;
      end
   end

   assign epc                    = epc_r;
   assign allow_hidden_use_of_x0 = use_urom;

endmodule

/* rv_core_top.sv */
// RV32I subset core
// Decode, execute, result and flow-control blocks with the code,
// data and interrupt ports
`timescale 1ns/1ps

module rv_core_top (
   input  logic              clk,
   input  logic              rst_n,
   output rv_isa_pkg::word_t code_addr,
   input  rv_isa_pkg::word_t code_rdata,
   input  logic              code_ready,
   output rv_isa_pkg::word_t data_addr,
   output rv_isa_pkg::word_t data_wdata,
   output logic              data_read,
   output logic              data_write,
   input  rv_isa_pkg::word_t data_rdata,
   input  logic              data_ready,
   input  logic              irq,
   output logic              irq_ack
);
   import rv_isa_pkg::*;

   word_t    inst_word;
   reg_idx_t rs1;
   reg_idx_t rs2;
   reg_idx_t rd;
   word_t    imm;
   alu_op_t  alu_op;
   logic     is_load;
   logic     is_store;
   logic     is_branch;
   logic     is_branch_ne;
   logic     is_jal;
   logic     is_mret;
   logic     reg_write;
   word_t    alu_result;
   word_t    store_data;
   word_t    branch_target;
   logic     branch_taken;
   word_t    pc;
   word_t    epc;
   word_t    wb_data;
   logic     wb_en;
   logic     stall;
   logic     output_new_pc;
   logic     data_access_cycle;
   logic     irq_return;
   logic     allow_hidden_use_of_x0;

   // All block ports share their net names
   rv_decode    rv_decode_inst    (.*);
   rv_execute   rv_execute_inst   (.*);
   rv_result    rv_result_inst    (.*);
   rv_flow_ctrl rv_flow_ctrl_inst (.*);

endmodule

/* rv_core_chk.sv */
// Protocol checker for the RV32I subset core
// Data strobe rules, irq_ack pulse width and the quiet cycle after reset
`timescale 1ns/1ps

module rv_core_chk (
   input logic clk,
   input logic rst_n,
   input logic data_read,
   input logic data_write,
   input logic data_ready,
   input logic irq_ack,
   input logic stall
);

   a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
      !(data_read && data_write))
      else $error("data_read and data_write high together");

   a_read_held: assert property (@(posedge clk) disable iff (!rst_n)
      data_read && !data_ready |=> data_read)
      else $error("data_read dropped before data_ready");

   a_write_held: assert property (@(posedge clk) disable iff (!rst_n)
      data_write && !data_ready |=> data_write)
      else $error("data_write dropped before data_ready");

   // Ack is a single-cycle pulse
   a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      irq_ack |=> !irq_ack)
      else $error("irq_ack longer than one cycle");

   // First cycle after reset holds the pipeline with the ports idle
   a_reset_quiet: assert property (@(posedge clk)
      $rose(rst_n) |-> stall && !data_read && !data_write && !irq_ack)
      else $error("core active in the first cycle after reset");

endmodule

bind rv_core_top rv_core_chk rv_core_chk_inst (.*);

/* rv_core_tb.sv */
// Testbench for the RV32I subset core
// Code and data memories with random ready delays, random irq requests,
// and an instruction-set model that predicts the program's store stream
`timescale 1ns/1ps
`include "rv_core_config.svh"

module rv_core_tb;
   import rv_isa_pkg::*;

   localparam int    MAX_IRQS       = 4;
   localparam int    TIMEOUT_CYCLES = 60 * 8 + MAX_IRQS * 80 + 200;
   localparam word_t HALT_PC        = 32'd26 * 4;
   localparam word_t CNT_ADDR       = 32'h300;

   logic  clk = 1'b0;
   logic  rst_n;
   word_t code_addr;
   word_t code_rdata;
   logic  code_ready;
   word_t data_addr;
   word_t data_wdata;
   logic  data_read;
   logic  data_write;
   word_t data_rdata;
   logic  data_ready;
   logic  irq;
   logic  irq_ack;

   word_t cmem [128];
   word_t dmem [1024];
   word_t exp_addr_q[$];
   word_t exp_data_q[$];
   word_t obs_addr_q[$];
   word_t obs_data_q[$];
   logic [15:0] lfsr = 16'd72;
   word_t fetch_addr = `RV_RESET_PC;
   word_t last_fetch = '1;
   logic  ack_at_edge = 1'b0;
   int    code_wait;
   int    data_wait;
   logic  data_busy;
   int    acks;
   int    raised;
   int    prog_stores;
   int    mbox_stores;
   int    cnt_stores;
   int    n_expected;
   int    cycles;
   logic  finished;

   rv_core_top rv_core_top_inst (.*);

   always #10 clk = ~clk;

   function automatic word_t fill_word(input int idx);
      return word_t'(idx * 4) ^ 32'h5A00_0000;
   endfunction

   function automatic word_t enc_i(input word_t imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
      return {imm[11:0], rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'h33};
   endfunction

   function automatic word_t enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                    input word_t imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic word_t enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input word_t off);
      return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic word_t enc_jal(input logic [4:0] rd, input word_t off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   // Fibonacci LFSR stepped once per bit taken
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   // Instruction-set model of the program without interrupts
   function automatic void build_expected();
      word_t x [32];
      word_t m [1024];
      word_t pc;
      word_t w;
      word_t a;
      word_t imm_i;
      word_t imm_b;
      word_t imm_j;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      for (int i = 0; i < 32; i++) x[i] = '0;
      for (int i = 0; i < 1024; i++) m[i] = fill_word(i);
      pc = `RV_RESET_PC;
      for (int step = 0; step < 200 && pc != HALT_PC; step++) begin
         w = cmem[pc[8:2]];
         rd = w[11:7];
         rs1 = w[19:15];
         rs2 = w[24:20];
         imm_i = {{20{w[31]}}, w[31:20]};
         imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         a = pc + 4;
         case (w[6:0])
            7'h13: x[rd] = x[rs1] + imm_i;
            7'h03: x[rd] = m[(x[rs1] + imm_i) >> 2];
            7'h33: begin
               if (w[30]) x[rd] = x[rs1] - x[rs2];
               else if (w[14:12] == 3'b111) x[rd] = x[rs1] & x[rs2];
               else if (w[14:12] == 3'b110) x[rd] = x[rs1] | x[rs2];
               else x[rd] = x[rs1] + x[rs2];
            end
            7'h23: begin
               a = x[rs1] + {{20{w[31]}}, w[31:25], w[11:7]};
               m[a >> 2] = x[rs2];
               exp_addr_q.push_back(a);
               exp_data_q.push_back(x[rs2]);
               a = pc + 4;
            end
            7'h63: if ((x[rs1] != x[rs2]) == w[12]) a = pc + imm_b;
            7'h6f: begin
               x[rd] = pc + 4;
               a = pc + imm_j;
            end
            default: ;
         endcase
         x[0] = '0;
         pc = a;
      end
   endfunction

   task automatic check_equal(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         $display("ERROR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Fetch address and ack as the core registers them at the edge
   always @(posedge clk) begin
      fetch_addr  = code_addr;
      ack_at_edge = irq_ack;
   end

   // Memory models and irq source driven on the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (fetch_addr != last_fetch) begin
            code_wait = rand_bits(2);
            last_fetch = fetch_addr;
         end
         code_ready <= (code_wait == 0);
         if (code_wait != 0) code_wait--;
         code_rdata <= cmem[fetch_addr[8:2]];
         if ((data_read || data_write) && !data_busy) begin
            data_busy = 1'b1;
            data_wait = rand_bits(2);
         end
         if (data_busy && data_wait == 0) begin
            data_busy = 1'b0;
            data_ready <= 1'b1;
            if (data_write) begin
               dmem[data_addr[11:2]] = data_wdata;
               obs_addr_q.push_back(data_addr);
               obs_data_q.push_back(data_wdata);
            end else begin
               data_rdata <= dmem[data_addr[11:2]];
            end
         end else begin
            data_ready <= 1'b0;
            if (data_busy) data_wait--;
         end
         // irq is held until the edge that acknowledges it
         if (ack_at_edge) begin
            acks++;
            irq <= 1'b0;
         end else if (!irq && prog_stores < n_expected && raised < MAX_IRQS &&
                      rand_bits(3) == 0) begin
            irq <= 1'b1;
            raised++;
         end
      end
   end

   // Compare completed stores with the model's list
   always @(posedge clk) begin
      while (obs_addr_q.size() > 0) begin
         if (obs_addr_q[0] == `RV_MAILBOX_ADDR) begin
            mbox_stores++;
            check_equal("mailbox data_wdata", obs_data_q[0], 1);
            check_equal("mailbox stores vs irq_ack", mbox_stores, acks);
         end else if (obs_addr_q[0] == CNT_ADDR) begin
            cnt_stores++;
         end else if (exp_addr_q.size() == 0) begin
            $display("Store at %h after the program's last expected store", obs_addr_q[0]);
            $display("Test failures found");
            $fatal(1, "unexpected store");
         end else begin
            check_equal("data_addr", obs_addr_q[0], exp_addr_q.pop_front());
            check_equal("data_wdata", obs_data_q[0], exp_data_q.pop_front());
            prog_stores++;
         end
         void'(obs_addr_q.pop_front());
         void'(obs_data_q.pop_front());
      end
      if (prog_stores == n_expected && !irq && mbox_stores == acks &&
          cnt_stores == acks) begin
         finished <= 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $fatal(1, "timeout");
      end
   end

   initial begin
      rst_n = 1'b0;
      code_rdata = '0;
      code_ready = 1'b0;
      data_rdata = '0;
      data_ready = 1'b0;
      irq = 1'b0;
      data_busy = 1'b0;
      code_wait = 0;
      data_wait = 0;
      acks = 0;
      raised = 0;
      prog_stores = 0;
      mbox_stores = 0;
      cnt_stores = 0;
      cycles = 0;
      finished = 1'b0;
      for (int i = 0; i < 128; i++) cmem[i] = NOP_WORD;
      for (int i = 0; i < 1024; i++) dmem[i] = fill_word(i);
      dmem[CNT_ADDR[11:2]] = '0;
      cmem[0]  = enc_i(5, 0, 0, 1, 7'h13);
      cmem[1]  = enc_i(-3, 0, 0, 2, 7'h13);
      cmem[2]  = enc_r(7'h00, 2, 1, 3'b000, 3);
      cmem[3]  = enc_r(7'h20, 2, 1, 3'b000, 4);
      cmem[4]  = enc_r(7'h00, 4, 1, 3'b111, 5);
      cmem[5]  = enc_r(7'h00, 4, 1, 3'b110, 6);
      cmem[6]  = enc_sw(3, 0, 32'h40);
      cmem[7]  = enc_sw(4, 0, 32'h44);
      cmem[8]  = enc_sw(6, 0, 32'h48);
      cmem[9]  = enc_i(32'h44, 0, 3'b010, 7, 7'h03);
      cmem[10] = enc_i(1, 7, 0, 7, 7'h13);
      cmem[11] = enc_sw(7, 0, 32'h4c);
      cmem[12] = enc_br(3'b000, 1, 1, 8);
      cmem[13] = enc_sw(1, 0, 32'h50);
      cmem[14] = enc_br(3'b001, 1, 1, 8);
      cmem[15] = enc_sw(5, 0, 32'h54);
      cmem[16] = enc_br(3'b001, 3, 4, 8);
      cmem[17] = enc_sw(1, 0, 32'h58);
      cmem[18] = enc_jal(8, 8);
      cmem[19] = enc_sw(1, 0, 32'h5c);
      cmem[20] = enc_sw(8, 0, 32'h60);
      cmem[21] = enc_i(3, 0, 0, 9, 7'h13);
      cmem[22] = enc_i(-1, 9, 0, 9, 7'h13);
      cmem[23] = enc_sw(9, 0, 32'h64);
      cmem[24] = enc_br(3'b001, 9, 0, -8);
      cmem[25] = enc_sw(1, 0, 32'h68);
      // Idle loop keeps retiring so pending irqs are still taken
      cmem[27] = enc_jal(0, -4);
      cmem[64] = enc_i(CNT_ADDR, 0, 3'b010, 15, 7'h03);
      cmem[65] = enc_i(1, 15, 0, 15, 7'h13);
      cmem[66] = enc_sw(15, 0, CNT_ADDR);
      cmem[67] = MRET_WORD;
      build_expected();
      n_expected = exp_addr_q.size();
      repeat (5) begin
         @(negedge clk);
         check_equal("data_read", data_read, 0);
         check_equal("data_write", data_write, 0);
         check_equal("irq_ack", irq_ack, 0);
      end
      rst_n <= 1'b1;
      do @(negedge clk); while (!finished);
      check_equal("handler counter", dmem[CNT_ADDR[11:2]], acks);
      check_equal("irq_ack seen", acks != 0, 1);
      $display("All tests passed!");
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_flow_ctrl.sv
rv_core_top.sv
rv_core_chk.sv
rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_ctrl_pkg.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_result.sv
      - rv_flow_ctrl.sv
      - rv_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_core_chk.sv
      - rv_core_tb.sv
